// File: Makefile
# Verilator build and run for the exception unit testbench

VERILATOR ?= verilator
TOP       ?= tb_exception_unit
FILELIST  ?= exception_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh tb/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: exception_unit.f
+incdir+hdl
+incdir+tb
hdl/mips_pkg.sv
hdl/commit_stage.sv
hdl/exception.sv
hdl/cp0_regs.sv
hdl/exception_unit.sv
tb/tb_exception_unit.sv

// File: hdl/commit_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module commit_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 commit_valid,
    output logic                 commit_ready,
    input  mips_pkg::commit_t    commit_data,
    output logic                 held_valid,
    output mips_pkg::commit_t    held,
    input  mips_pkg::exception_t exc,
    input  mips_pkg::word_t      epc,
    output logic                 redirect_valid,
    input  logic                 redirect_ready,
    output mips_pkg::redirect_t  redirect,
    output logic                 retire
);

    logic need_redirect;
    logic accept;

    // an exception or ERET has to steer fetch before leaving
    assign need_redirect = held_valid & (exc.valid | held.is_eret);

    assign redirect_valid = need_redirect;

    always_comb begin
        redirect.is_exception = exc.valid;
        // exception wins over a simultaneous ERET
        if (exc.valid) begin
            redirect.target = exc.location;
        end else begin
            redirect.target = epc;
        end
    end

    // leaves at once, or on the redirect handshake
    assign retire = held_valid & (~need_redirect | redirect_ready);

    assign commit_ready = ~held_valid | retire;
    assign accept       = commit_valid & commit_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (commit_ready) begin
            held_valid <= commit_valid;
        end
    end

    // instruction payload, loaded on every accepted transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= commit_data;
        end
    end

    // stalled redirect must not move until fetch takes it
    redirect_stable_a: assert property (
        @(posedge clk) disable iff (rst)
        redirect_valid && !redirect_ready |=>
            redirect_valid && $stable(redirect) && $stable(held)
    ) else $error("redirect changed while stalled");

    // a retired instruction is gone unless a new one came in
    retire_clears_a: assert property (
        @(posedge clk) disable iff (rst)
        retire && !accept |=> !held_valid
    ) else $error("held instruction stayed after retire");

endmodule

`default_nettype wire

// File: hdl/cp0_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module cp0_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`HW_INT_W-1:0]      hw_int,
    input  logic                      retire,
    input  mips_pkg::commit_t         held,
    input  mips_pkg::exception_t      exc,
    output mips_pkg::cp0_regs_t       regs,
    output mips_pkg::interrupt_info_t interrupt_info,
    input  mips_pkg::cp0_addr_t       cp0_raddr,
    output mips_pkg::word_t           cp0_rdata
);

    mips_pkg::cp0_status_t wr_status;
    mips_pkg::cp0_cause_t  wr_cause;
    mips_pkg::word_t       exc_epc;
    logic                  take_exc;
    logic                  take_eret;
    logic                  take_mtc0;
    logic                  addr_fault;

    // MTC0 data viewed as the register layouts
    assign wr_status = mips_pkg::cp0_status_t'(held.cp0_wdata);
    assign wr_cause  = mips_pkg::cp0_cause_t'(held.cp0_wdata);

    // branch address for an instruction in a delay slot
    assign exc_epc = exc.in_delay_slot ? exc.pc - `INSTR_BYTES : exc.pc;

    assign addr_fault = (exc.code == `CODE_ADEL) | (exc.code == `CODE_ADES);

    // one update per instruction with the exception first
    assign take_exc  = retire & exc.valid;
    assign take_eret = retire & ~exc.valid & held.is_eret;
    assign take_mtc0 = retire & ~exc.valid & ~held.is_eret & held.is_mtc0;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0;
        end else begin
            // hardware lines are level sensitive
            regs.cause.ip[7:2] <= hw_int;

            if (take_exc) begin
                regs.epc            <= exc_epc;
                regs.cause.bd       <= exc.in_delay_slot;
                regs.cause.exc_code <= exc.code;
                regs.status.exl    <= 1'b1;
                if (addr_fault) begin
                    regs.badvaddr <= exc.badvaddr;
                end
            end

            if (take_eret) begin
                regs.status.exl <= 1'b0;
            end

            if (take_mtc0) begin
                case (held.cp0_waddr)
                    `CP0_STATUS: begin
                        regs.status.im  <= wr_status.im;
                        regs.status.exl <= wr_status.exl;
                        regs.status.ie  <= wr_status.ie;
                    end
                    `CP0_CAUSE: begin
                        // software interrupt bits only
                        regs.cause.ip[1:0] <= wr_cause.ip[1:0];
                    end
                    `CP0_EPC: begin
                        regs.epc <= held.cp0_wdata;
                    end
                    `CP0_BADVADDR: begin
                        regs.badvaddr <= held.cp0_wdata;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign interrupt_info = regs.cause.ip & regs.status.im;

    // read port returns zero for unimplemented numbers
    always_comb begin
        case (cp0_raddr)
            `CP0_STATUS:   cp0_rdata = regs.status;
            `CP0_CAUSE:    cp0_rdata = regs.cause;
            `CP0_EPC:      cp0_rdata = regs.epc;
            `CP0_BADVADDR: cp0_rdata = regs.badvaddr;
            default:       cp0_rdata = '0;
        endcase
    end

    // architectural state moves only when an instruction retires
    retire_only_a: assert property (
        @(posedge clk) disable iff (rst)
        !retire |=> $stable(regs.status) && $stable(regs.epc) && $stable(regs.badvaddr)
                    && $stable(regs.cause.bd) && $stable(regs.cause.exc_code)
    ) else $error("CP0 state changed without a retiring instruction");

endmodule

`default_nettype wire

// File: hdl/exception.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module exception (
    input  logic                      rst,
    input  logic                      held_valid,
    input  mips_pkg::commit_t         held,
    input  mips_pkg::cp0_regs_t       cp0,
    input  mips_pkg::interrupt_info_t interrupt_info,
    output mips_pkg::exception_t      exc
);

    logic                interrupt_valid;
    logic                flag_valid;
    mips_pkg::exc_code_t flag_code;

    // only a real instruction can carry the interrupt
    assign interrupt_valid = held_valid
                           & (interrupt_info != '0)
                           & cp0.status.ie
                           & ~cp0.status.exl;

    // fixed priority among the instruction's own flags
    always_comb begin
        flag_valid = held_valid;
        flag_code  = '0;
        if (held.exception_instr) begin
            flag_code = `CODE_ADEL;
        end else if (held.exception_ri) begin
            flag_code = `CODE_RI;
        end else if (held.exception_of) begin
            flag_code = `CODE_OV;
        end else if (held.exception_sys) begin
            flag_code = `CODE_SYS;
        end else if (held.exception_bp) begin
            flag_code = `CODE_BP;
        end else if (held.exception_load) begin
            flag_code = `CODE_ADEL;
        end else if (held.exception_save) begin
            flag_code = `CODE_ADES;
        end else begin
            flag_valid = 1'b0;
        end
    end

    always_comb begin
        exc.valid         = (interrupt_valid | flag_valid) & ~rst;
        exc.code          = interrupt_valid ? `CODE_INT : flag_code;
        exc.pc            = held.pc;
        exc.in_delay_slot = held.in_delay_slot;
        // a fetch error faults on the pc itself
        exc.badvaddr      = held.exception_instr ? held.pc : held.vaddr;
        exc.location      = `EXC_ENTRY;
    end

endmodule

`default_nettype wire

// File: hdl/exception_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module exception_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 commit_valid,
    output logic                 commit_ready,
    input  mips_pkg::commit_t    commit_data,
    output logic                 redirect_valid,
    input  logic                 redirect_ready,
    output mips_pkg::redirect_t  redirect,
    input  logic [`HW_INT_W-1:0] hw_int,
    input  mips_pkg::cp0_addr_t  cp0_raddr,
    output mips_pkg::word_t      cp0_rdata
);

    // instruction in the commit register
    logic                      held_valid;
    mips_pkg::commit_t         held;
    logic                      retire;

    // cause selection and CP0 state
    mips_pkg::exception_t      exc;
    mips_pkg::cp0_regs_t       cp0;
    mips_pkg::interrupt_info_t interrupt_info;

    commit_stage i_commit_stage (
        .clk            (clk),
        .rst            (rst),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_data    (commit_data),
        .held_valid     (held_valid),
        .held           (held),
        .exc            (exc),
        .epc            (cp0.epc),
        .redirect_valid (redirect_valid),
        .redirect_ready (redirect_ready),
        .redirect       (redirect),
        .retire         (retire)
    );

    exception i_exception (
        .rst            (rst),
        .held_valid     (held_valid),
        .held           (held),
        .cp0            (cp0),
        .interrupt_info (interrupt_info),
        .exc            (exc)
    );

    cp0_regs i_cp0_regs (
        .clk            (clk),
        .rst            (rst),
        .hw_int         (hw_int),
        .retire         (retire),
        .held           (held),
        .exc            (exc),
        .regs           (cp0),
        .interrupt_info (interrupt_info),
        .cp0_raddr      (cp0_raddr),
        .cp0_rdata      (cp0_rdata)
    );

endmodule

`default_nettype wire

// File: hdl/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath widths
`define WORD_W      32
`define EXC_CODE_W  5
`define HW_INT_W    6
`define CP0_ADDR_W  5

// Cause.ExcCode values
`define CODE_INT    5'd0
`define CODE_ADEL   5'd4
`define CODE_ADES   5'd5
`define CODE_SYS    5'd8
`define CODE_BP     5'd9
`define CODE_RI     5'd10
`define CODE_OV     5'd12

// CP0 register numbers, select 0 only
`define CP0_BADVADDR  5'd8
`define CP0_STATUS    5'd12
`define CP0_CAUSE     5'd13
`define CP0_EPC       5'd14

// single exception entry, no BEV or EXL offsets
`define EXC_ENTRY   32'hBFC00380

// delay slot correction for EPC
`define INSTR_BYTES 32'd4

`endif

// File: hdl/mips_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`EXC_CODE_W-1:0] exc_code_t;
    typedef logic [`CP0_ADDR_W-1:0] cp0_addr_t;

    // pending and enabled interrupts, Cause.IP & Status.IM
    typedef logic [7:0] interrupt_info_t;

    typedef struct packed {
        logic [15:0] zero_hi;
        logic [7:0]  im;
        logic [5:0]  zero_lo;
        logic        exl;
        logic        ie;
    } cp0_status_t;

    typedef struct packed {
        logic        bd;
        logic [14:0] zero_hi;
        logic [7:0]  ip;
        logic        zero_mid;
        exc_code_t   exc_code;
        logic [1:0]  zero_lo;
    } cp0_cause_t;

    typedef struct packed {
        cp0_status_t status;
        cp0_cause_t  cause;
        word_t       epc;
        word_t       badvaddr;
    } cp0_regs_t;

    // one retiring instruction as seen by the commit end
    typedef struct packed {
        word_t     pc;
        word_t     vaddr;
        logic      in_delay_slot;
        logic      exception_instr;
        logic      exception_ri;
        logic      exception_of;
        logic      exception_sys;
        logic      exception_bp;
        logic      exception_load;
        logic      exception_save;
        logic      is_eret;
        logic      is_mtc0;
        cp0_addr_t cp0_waddr;
        word_t     cp0_wdata;
    } commit_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     pc;
        logic      in_delay_slot;
        word_t     badvaddr;
        word_t     location;
    } exception_t;

    typedef struct packed {
        word_t target;
        logic  is_exception;
    } redirect_t;

endpackage

`default_nettype wire

// File: tb/tb_exception_tests.svh
    // flag bits: 0 fetch, 1 ri, 2 ov, 3 sys, 4 bp, 5 load, 6 store
    function automatic mips_pkg::commit_t make_instr(input mips_pkg::word_t pc,
                                                     input mips_pkg::word_t vaddr,
                                                     input logic slot, input logic [6:0] flags);
        mips_pkg::commit_t c;
        c                 = '0;
        c.pc              = pc;
        c.vaddr           = vaddr;
        c.in_delay_slot   = slot;
        c.exception_instr = flags[0];
        c.exception_ri    = flags[1];
        c.exception_of    = flags[2];
        c.exception_sys   = flags[3];
        c.exception_bp    = flags[4];
        c.exception_load  = flags[5];
        c.exception_save  = flags[6];
        return c;
    endfunction

    // highest priority first, as listed for the cause selection
    function automatic mips_pkg::exc_code_t flag_code(input int idx);
        case (idx)
            0: return `CODE_ADEL;
            1: return `CODE_RI;
            2: return `CODE_OV;
            3: return `CODE_SYS;
            4: return `CODE_BP;
            5: return `CODE_ADEL;
            default: return `CODE_ADES;
        endcase
    endfunction

    function automatic mips_pkg::redirect_t make_redirect(input mips_pkg::word_t target,
                                                          input logic is_exception);
        mips_pkg::redirect_t r;
        r.target       = target;
        r.is_exception = is_exception;
        return r;
    endfunction

    // Cause with no pending interrupts
    function automatic mips_pkg::word_t cause_word(input logic bd, input mips_pkg::exc_code_t code);
        return {bd, 24'b0, code, 2'b0};
    endfunction

    function automatic mips_pkg::word_t random_word();
        return $urandom;
    endfunction

    function automatic mips_pkg::word_t random_pc();
        return $urandom & 32'hFFFF_FFFC;
    endfunction

    function automatic mips_pkg::commit_t random_plain();
        return make_instr(random_pc(), random_word(), 1'b0, 7'b0);
    endfunction

    task automatic write_cp0(input mips_pkg::cp0_addr_t addr, input mips_pkg::word_t data);
        mips_pkg::commit_t c;
        c           = random_plain();
        c.is_mtc0   = 1'b1;
        c.cp0_waddr = addr;
        c.cp0_wdata = data;
        send_commit(c);
    endtask

    task automatic expect_no_redirect(input string name, input mips_pkg::commit_t c);
        send_commit(c);
        @(negedge clk);
        check_bit({name, " redirect_valid"}, 1'b0, redirect_valid);
        check_bit({name, " commit_ready"}, 1'b1, commit_ready);
        wait_drive_slot();
    endtask

    task automatic take_exception(input string name, input mips_pkg::commit_t c);
        send_commit(c);
        expect_redirect(name, make_redirect(`EXC_ENTRY, 1'b1), 0);
    endtask

    task automatic return_from_exception(input string name, input mips_pkg::word_t epc);
        mips_pkg::commit_t c;
        mips_pkg::word_t   status;
        c         = random_plain();
        c.is_eret = 1'b1;
        send_commit(c);
        expect_redirect(name, make_redirect(epc, 1'b0), 0);
        read_cp0(`CP0_STATUS, status);
        check_bit({name, " exl"}, 1'b0, status[1]);
    endtask

    task automatic test_plain_retire();
        repeat (20) begin
            expect_no_redirect("plain retire", random_plain());
        end
        expect_cp0("plain retire status", `CP0_STATUS, '0);
        expect_cp0("plain retire cause", `CP0_CAUSE, '0);
    endtask

    task automatic test_priority();
        mips_pkg::word_t pc;
        mips_pkg::word_t cause;
        for (int hi = 0; hi < 7; hi++) begin
            for (int lo = hi + 1; lo < 7; lo++) begin
                pc = random_pc();
                take_exception("priority",
                    make_instr(pc, random_word(), 1'b0, 7'(1 << hi) | 7'(1 << lo)));
                read_cp0(`CP0_CAUSE, cause);
                check_code("priority code", flag_code(hi), cause[6:2]);
                return_from_exception("priority eret", pc);
            end
        end
    endtask

    task automatic test_recorded_state();
        mips_pkg::word_t pc;
        mips_pkg::word_t vaddr;
        // EPC points at the branch for a delay slot
        pc = random_pc();
        take_exception("delay slot", make_instr(pc, random_word(), 1'b1, 7'b000_0100));
        expect_cp0("delay slot epc", `CP0_EPC, pc - 32'd4);
        expect_cp0("delay slot cause", `CP0_CAUSE, cause_word(1'b1, `CODE_OV));
        return_from_exception("delay slot eret", pc - 32'd4);
        pc = random_pc();
        take_exception("no slot", make_instr(pc, random_word(), 1'b0, 7'b000_1000));
        expect_cp0("no slot epc", `CP0_EPC, pc);
        expect_cp0("no slot cause", `CP0_CAUSE, cause_word(1'b0, `CODE_SYS));
        return_from_exception("no slot eret", pc);
        pc    = random_pc();
        vaddr = random_word();
        take_exception("load error", make_instr(pc, vaddr, 1'b0, 7'b010_0000));
        expect_cp0("load error badvaddr", `CP0_BADVADDR, vaddr);
        return_from_exception("load error eret", pc);
        pc    = random_pc();
        vaddr = random_word();
        take_exception("store error", make_instr(pc, vaddr, 1'b0, 7'b100_0000));
        expect_cp0("store error badvaddr", `CP0_BADVADDR, vaddr);
        return_from_exception("store error eret", pc);
        pc = random_pc();
        take_exception("fetch error", make_instr(pc, random_word(), 1'b0, 7'b000_0001));
        expect_cp0("fetch error badvaddr", `CP0_BADVADDR, pc);
        return_from_exception("fetch error eret", pc);
        // overflow leaves the last fault address alone
        take_exception("overflow", make_instr(random_pc(), random_word(), 1'b0, 7'b000_0100));
        expect_cp0("overflow badvaddr", `CP0_BADVADDR, pc);
    endtask

    task automatic interrupt_case(input string name, input mips_pkg::word_t im_bit,
                                  input logic software);
        mips_pkg::word_t pc;
        mips_pkg::word_t cause;
        write_cp0(`CP0_STATUS, im_bit);
        expect_no_redirect({name, " ie clear"}, random_plain());
        write_cp0(`CP0_STATUS, (32'h0000_FF00 & ~im_bit) | 32'h1);
        expect_no_redirect({name, " im clear"}, random_plain());
        write_cp0(`CP0_STATUS, im_bit | 32'h1);
        pc = random_pc();
        take_exception({name, " taken"}, make_instr(pc, random_word(), 1'b0, 7'b0));
        read_cp0(`CP0_CAUSE, cause);
        check_code({name, " code"}, `CODE_INT, cause[6:2]);
        expect_no_redirect({name, " exl set"}, random_plain());
        // drop the request before leaving the handler
        if (software) begin
            write_cp0(`CP0_CAUSE, '0);
        end else begin
            hw_int = '0;
        end
        wait_drive_slot();
        wait_drive_slot();
        return_from_exception({name, " eret"}, pc);
        write_cp0(`CP0_STATUS, '0);
    endtask

    task automatic test_interrupts();
        int line;
        line   = int'($urandom % 6);
        hw_int = 6'(1 << line);
        wait_drive_slot();
        wait_drive_slot();
        interrupt_case("hw interrupt", 32'h1 << (10 + line), 1'b0);
        write_cp0(`CP0_CAUSE, 32'h0000_0100);
        interrupt_case("sw interrupt", 32'h0000_0100, 1'b1);
    endtask

    task automatic test_eret();
        mips_pkg::word_t pc;
        mips_pkg::word_t status;
        pc = random_pc();
        take_exception("eret setup", make_instr(pc, random_word(), 1'b0, 7'b001_0000));
        expect_cp0("eret epc", `CP0_EPC, pc);
        read_cp0(`CP0_STATUS, status);
        check_bit("eret exl before", 1'b1, status[1]);
        return_from_exception("eret", pc);
    endtask

    task automatic test_back_pressure();
        mips_pkg::word_t pc;
        mips_pkg::word_t vaddr;
        int              stalls;
        pc     = random_pc();
        vaddr  = random_word();
        stalls = 1 + int'($urandom % 8);
        send_commit(make_instr(pc, vaddr, 1'b1, 7'b100_0000));
        expect_redirect("back pressure", make_redirect(`EXC_ENTRY, 1'b1), stalls);
        expect_cp0("back pressure epc", `CP0_EPC, pc - 32'd4);
        expect_cp0("back pressure badvaddr", `CP0_BADVADDR, vaddr);
        expect_cp0("back pressure cause", `CP0_CAUSE, cause_word(1'b1, `CODE_ADES));
        return_from_exception("back pressure eret", pc - 32'd4);
    endtask

// File: tb/tb_exception_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module tb_exception_unit;

    // six tests of under 200 cycles each, plus margin
    localparam int MAX_CYCLES = 2000;

    logic                 clk;
    logic                 rst;
    logic                 commit_valid;
    logic                 commit_ready;
    mips_pkg::commit_t    commit_data;
    logic                 redirect_valid;
    logic                 redirect_ready;
    mips_pkg::redirect_t  redirect;
    logic [`HW_INT_W-1:0] hw_int;
    mips_pkg::cp0_addr_t  cp0_raddr;
    mips_pkg::word_t      cp0_rdata;
    int                   cycles = 0;

    exception_unit i_dut (
        .clk            (clk),
        .rst            (rst),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_data    (commit_data),
        .redirect_valid (redirect_valid),
        .redirect_ready (redirect_ready),
        .redirect       (redirect),
        .hw_int         (hw_int),
        .cp0_raddr      (cp0_raddr),
        .cp0_rdata      (cp0_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t expected,
                              input mips_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_code(input string name, input mips_pkg::exc_code_t expected,
                              input mips_pkg::exc_code_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_redirect(input string name, input mips_pkg::redirect_t expected,
                                  input mips_pkg::redirect_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error %s: expected %h/%b, actual %h/%b", name,
                expected.target, expected.is_exception, actual.target, actual.is_exception));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // inputs change 2 ns after the rising edge
    task automatic wait_drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic read_cp0(input mips_pkg::cp0_addr_t addr, output mips_pkg::word_t data);
        cp0_raddr = addr;
        #1;
        data = cp0_rdata;
    endtask

    task automatic expect_cp0(input string name, input mips_pkg::cp0_addr_t addr,
                              input mips_pkg::word_t expected);
        mips_pkg::word_t value;
        read_cp0(addr, value);
        check_word(name, expected, value);
    endtask

    task automatic send_commit(input mips_pkg::commit_t c);
        commit_valid = 1'b1;
        commit_data  = c;
        @(negedge clk);
        while (!commit_ready) begin
            @(negedge clk);
        end
        wait_drive_slot();
        commit_valid = 1'b0;
    endtask

    task automatic expect_redirect(input string name, input mips_pkg::redirect_t expected,
                                   input int stalls);
        mips_pkg::word_t old_status;
        mips_pkg::word_t old_cause;
        mips_pkg::word_t old_epc;
        mips_pkg::word_t old_badvaddr;
        read_cp0(`CP0_STATUS, old_status);
        read_cp0(`CP0_CAUSE, old_cause);
        read_cp0(`CP0_EPC, old_epc);
        read_cp0(`CP0_BADVADDR, old_badvaddr);
        @(negedge clk);
        while (!redirect_valid) begin
            @(negedge clk);
        end
        check_redirect(name, expected, redirect);
        // fetch holds off and nothing may move
        repeat (stalls) begin
            wait_drive_slot();
            expect_cp0({name, " status held"}, `CP0_STATUS, old_status);
            expect_cp0({name, " cause held"}, `CP0_CAUSE, old_cause);
            expect_cp0({name, " epc held"}, `CP0_EPC, old_epc);
            expect_cp0({name, " badvaddr held"}, `CP0_BADVADDR, old_badvaddr);
            @(negedge clk);
            check_bit({name, " valid held"}, 1'b1, redirect_valid);
            check_bit({name, " commit_ready low"}, 1'b0, commit_ready);
            check_redirect({name, " held"}, expected, redirect);
        end
        wait_drive_slot();
        redirect_ready = 1'b1;
        @(negedge clk);
        check_bit({name, " valid at handshake"}, 1'b1, redirect_valid);
        wait_drive_slot();
        redirect_ready = 1'b0;
    endtask

    `include "tb_exception_tests.svh"

    initial begin
        rst            = 1'b1;
        commit_valid   = 1'b0;
        commit_data    = '0;
        redirect_ready = 1'b0;
        hw_int         = '0;
        cp0_raddr      = '0;
        void'($urandom(32'h536b));
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_bit("reset commit_ready", 1'b1, commit_ready);
        check_bit("reset redirect_valid", 1'b0, redirect_valid);
        expect_cp0("reset status", `CP0_STATUS, '0);
        expect_cp0("reset cause", `CP0_CAUSE, '0);
        expect_cp0("reset epc", `CP0_EPC, '0);
        expect_cp0("reset badvaddr", `CP0_BADVADDR, '0);
        wait_drive_slot();
        test_plain_retire();
        test_priority();
        test_recorded_state();
        test_interrupts();
        test_eret();
        test_back_pressure();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
